// File: src.f
+incdir+.
sample_fifo_pkg.sv
fifo_bram.sv
fwft_fifo.sv
fifo_status_apb.sv
sample_fifo_top.sv
tb_sample_fifo.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the sample FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sample_fifo -f src.f

sim_output=$(./obj_dir/Vtb_sample_fifo)
echo "$sim_output"

if echo "$sim_output" | grep -qx "TEST PASSED"; then
  exit 0
else
  exit 1
fi

// File: tb_sample_fifo.sv
// Testbench for the sample FIFO
// Random traffic against a queue model, plus APB register checks
`include "sample_fifo_settings.svh"

module tb_sample_fifo
  import sample_fifo_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned RNG_SEED    = 32'h3959_d9e7;
  localparam int          CAPACITY    = `FIFO_DEPTH + 3;
  localparam int          TRAFFIC_LEN = 3000;
  localparam int          LEVEL_ITERS = 300;
  localparam int          STATUS_W    = $bits(fifo_status_t);
  localparam int          DRAIN_LIMIT = 2 * CAPACITY + 20;

  // Rough cycle count of each test, drains included
  localparam int LEN_RESET   = 30;
  localparam int LEN_TRAFFIC = TRAFFIC_LEN + DRAIN_LIMIT;
  localparam int LEN_LEVEL   = 3 * LEVEL_ITERS + 10 + DRAIN_LIMIT;
  localparam int LEN_FILL    = CAPACITY + 40 + DRAIN_LIMIT;
  localparam int LEN_APB_ERR = 20;
  localparam int CYCLE_LIMIT =
    4 * (LEN_RESET + LEN_TRAFFIC + LEN_LEVEL + LEN_FILL + LEN_APB_ERR) + 1000;

  logic     RD_CLK;
  logic     RESET;
  logic     wren;
  sample_t  din;
  logic     rden;
  sample_t  dout;
  logic     empty;
  logic     full;
  logic     almost_full;
  logic     high;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;

  sample_t                   model_q[$];
  logic [`TOTAL_LEVEL_W-1:0] threshold_model;
  logic [`OVF_CNT_W-1:0]     ovf_model;
  int                        idle_cycles;
  int                        cycle_count = 0;
  int                        check_count;
  int                        error_count;

  sample_fifo_top i_sample_fifo_top (
    .RD_CLK      (RD_CLK),
    .RESET       (RESET),
    .wren        (wren),
    .din         (din),
    .rden        (rden),
    .dout        (dout),
    .empty       (empty),
    .full        (full),
    .almost_full (almost_full),
    .high        (high),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp)
  );

  initial begin
    RD_CLK = 1'b0;
    forever #50 RD_CLK = ~RD_CLK;
  end

  always @(posedge RD_CLK) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Timeout: run stopped after %0d cycles", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    check_count++;
    assert (cond) else begin
      error_count++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("%s finished with %0d errors", name, error_count - errors_before);
  endtask

  // Drive after the edge, sample at the falling edge, then let the model
  // follow what the DUT accepted and popped at the rising edge
  task automatic run_cycle(input logic wr, input logic rd);
    sample_t s;
    logic    accepted;
    logic    popped;
    s    = sample_t'($urandom);
    wren = wr;
    din  = s;
    rden = rd;
    @(negedge RD_CLK);
    accepted = wren && !full;
    popped   = rden && !empty;
    if (!empty) begin
      check_true(model_q.size() != 0, "DUT shows a sample while the model queue is empty");
      if (model_q.size() != 0) begin
        check_eq("dout", dout, model_q[0]);
      end
    end
    if (idle_cycles >= 3) begin
      check_eq("empty", empty, model_q.size() == 0);
    end
    check_eq("high", high, model_q.size() >= threshold_model);
    if (wren && full && ovf_model != '1) begin
      ovf_model++;
    end
    @(posedge RD_CLK);
    if (popped) begin
      void'(model_q.pop_front());
    end
    if (accepted) begin
      model_q.push_back(s);
      idle_cycles = 0;
    end else begin
      idle_cycles++;
    end
    #5;
  endtask

  task automatic drain_model();
    int guard;
    guard = 0;
    while (model_q.size() != 0 && guard < DRAIN_LIMIT) begin
      run_cycle(1'b0, 1'b1);
      guard++;
    end
    check_true(model_q.size() == 0, "FIFO did not drain within the cycle limit");
    repeat (3) begin
      run_cycle(1'b0, 1'b0);
    end
  endtask

  // Setup phase, then access phase; pready is expected in the access cycle
  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
    wren            = 1'b0;
    rden            = 1'b0;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge RD_CLK);
    #5;
    apb_req.penable = 1'b1;
    @(negedge RD_CLK);
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    check_eq("pready", apb_rsp.pready, 1'b1);
    @(posedge RD_CLK);
    #5;
    apb_req = '0;
  endtask

  task automatic reg_read(input logic [11:0] addr, output logic [31:0] data);
    logic slverr;
    apb_access(1'b0, addr, 32'h0, data, slverr);
    check_eq("pslverr", slverr, 1'b0);
  endtask

  task automatic reg_write(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        slverr;
    apb_access(1'b1, addr, data, rdata, slverr);
    check_eq("pslverr", slverr, 1'b0);
  endtask

  task automatic read_status(output fifo_status_t st);
    logic [31:0] data;
    reg_read(`REG_STATUS, data);
    st = fifo_status_t'(data[STATUS_W-1:0]);
  endtask

  task automatic test_reset_state();
    int           errors_before;
    logic [31:0]  data;
    fifo_status_t st;
    errors_before = error_count;
    check_eq("empty", empty, 1'b1);
    check_eq("full", full, 1'b0);
    check_eq("almost_full", almost_full, 1'b0);
    check_eq("high", high, 1'b0);
    check_eq("dout", dout, 32'h0);
    read_status(st);
    check_eq("status.level", st.level, 0);
    check_eq("status.empty", st.empty, 1'b1);
    reg_read(`REG_CTRL, data);
    check_eq("ctrl", data, `FIFO_DEPTH);
    reg_read(`REG_OVF, data);
    check_eq("ovf", data, 0);
    report_test("reset_state", errors_before);
  endtask

  task automatic test_random_order();
    int errors_before;
    errors_before = error_count;
    for (int i = 0; i < TRAFFIC_LEN; i++) begin
      run_cycle($urandom_range(0, 1) == 1, $urandom_range(0, 1) == 1);
    end
    drain_model();
    report_test("random_order", errors_before);
  endtask

  task automatic test_level_high();
    int           errors_before;
    logic [31:0]  data;
    fifo_status_t st;
    errors_before   = error_count;
    threshold_model = $urandom_range(1, 48);
    reg_write(`REG_CTRL, threshold_model);
    reg_read(`REG_CTRL, data);
    check_eq("ctrl", data, threshold_model);
    // Slight write bias so the level climbs through the threshold
    for (int i = 0; i < LEVEL_ITERS; i++) begin
      run_cycle($urandom_range(0, 99) < 60, $urandom_range(0, 99) < 40);
      read_status(st);
      check_eq("status.level", st.level, model_q.size());
      check_eq("high", high, model_q.size() >= threshold_model);
    end
    drain_model();
    report_test("level_high", errors_before);
  endtask

  task automatic test_fill_overflow();
    int          errors_before;
    int          start_size;
    int          guard;
    logic [31:0] data;
    errors_before = error_count;
    start_size    = model_q.size();
    guard         = 0;
    while (!full && guard < CAPACITY + 20) begin
      run_cycle(1'b1, 1'b0);
      guard++;
      if (model_q.size() >= CAPACITY - `ALMOST_FULL_MARGIN) begin
        check_eq("almost_full", almost_full, 1'b1);
      end
    end
    check_true(full, "full never rose while filling with rden low");
    check_eq("accepted words", model_q.size() - start_size, CAPACITY);
    repeat (7) begin
      run_cycle(1'b1, 1'b0);
    end
    check_eq("words after overflow", model_q.size(), CAPACITY);
    reg_read(`REG_OVF, data);
    check_eq("ovf", data, 7);
    reg_write(`REG_OVF, $urandom);
    ovf_model = '0;
    reg_read(`REG_OVF, data);
    check_eq("ovf", data, 0);
    // Three more dropped writes leave the counter nonzero
    repeat (3) begin
      run_cycle(1'b1, 1'b0);
    end
    drain_model();
    report_test("fill_overflow", errors_before);
  endtask

  task automatic test_apb_error();
    int           errors_before;
    logic [31:0]  data;
    logic         slverr;
    fifo_status_t st;
    errors_before = error_count;
    apb_access(1'b0, 12'h00C, 32'h0, data, slverr);
    check_eq("pslverr on read", slverr, 1'b1);
    apb_access(1'b1, 12'h00C, $urandom, data, slverr);
    check_eq("pslverr on write", slverr, 1'b1);
    reg_read(`REG_CTRL, data);
    check_eq("ctrl", data, threshold_model);
    reg_read(`REG_OVF, data);
    check_eq("ovf", data, ovf_model);
    read_status(st);
    check_eq("status.level", st.level, model_q.size());
    report_test("apb_error", errors_before);
  endtask

  initial begin
    void'($urandom(RNG_SEED));
    RESET           = 1'b1;
    wren            = 1'b0;
    din             = '0;
    rden            = 1'b0;
    apb_req         = '0;
    threshold_model = `FIFO_DEPTH;
    ovf_model       = '0;
    idle_cycles     = 3;
    check_count     = 0;
    error_count     = 0;
    repeat (4) @(posedge RD_CLK);
    #5;
    RESET = 1'b0;

    test_reset_state();
    test_random_order();
    test_level_high();
    test_fill_overflow();
    test_apb_error();

    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: sample_fifo_top.sv
// Sample FIFO top level
// FWFT data path plus its APB status and control registers
module sample_fifo_top
  import sample_fifo_pkg::*;
(
  input  logic     RD_CLK,
  input  logic     RESET,
  input  logic     wren,
  input  sample_t  din,
  input  logic     rden,
  output sample_t  dout,
  output logic     empty,
  output logic     full,
  output logic     almost_full,
  output logic     high,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp
);

  fifo_status_t status;
  logic         overflow;

  fwft_fifo #(
    .payload_t (sample_t)
  ) i_fwft_fifo (
    .RD_CLK      (RD_CLK),
    .RESET       (RESET),
    .wren        (wren),
    .din         (din),
    .rden        (rden),
    .dout        (dout),
    .empty       (empty),
    .full        (full),
    .almost_full (almost_full),
    .overflow    (overflow),
    .status      (status)
  );

  fifo_status_apb i_fifo_status_apb (
    .RD_CLK   (RD_CLK),
    .RESET    (RESET),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .status   (status),
    .overflow (overflow),
    .high     (high)
  );

endmodule

// File: fifo_status_apb.sv
// APB register block for the sample FIFO
// Holds the high-water threshold and a saturating overflow counter
`include "sample_fifo_settings.svh"

module fifo_status_apb
  import sample_fifo_pkg::*;
(
  input  logic         RD_CLK,
  input  logic         RESET,
  input  apb_req_t     apb_req,
  output apb_rsp_t     apb_rsp,
  input  fifo_status_t status,
  input  logic         overflow,
  output logic         high
);

  localparam int STATUS_W = $bits(fifo_status_t);
  localparam logic [`TOTAL_LEVEL_W-1:0] THRESH_RST = `FIFO_DEPTH;

  logic [`TOTAL_LEVEL_W-1:0] threshold;
  logic [`OVF_CNT_W-1:0]     ovf_cnt;
  logic                      access;
  logic                      hit_ctrl;
  logic                      hit_status;
  logic                      hit_ovf;

  assign access     = apb_req.psel && apb_req.penable;
  assign hit_ctrl   = (apb_req.paddr == `REG_CTRL);
  assign hit_status = (apb_req.paddr == `REG_STATUS);
  assign hit_ovf    = (apb_req.paddr == `REG_OVF);

  assign apb_rsp.pready  = 1'b1; // Zero wait states
  assign apb_rsp.pslverr = access && !(hit_ctrl || hit_status || hit_ovf);

  always_comb begin
    apb_rsp.prdata = '0;
    if (hit_ctrl) begin
      apb_rsp.prdata = {{(32 - `TOTAL_LEVEL_W){1'b0}}, threshold};
    end else if (hit_status) begin
      apb_rsp.prdata = {{(32 - STATUS_W){1'b0}}, status};
    end else if (hit_ovf) begin
      apb_rsp.prdata = {{(32 - `OVF_CNT_W){1'b0}}, ovf_cnt};
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      threshold <= THRESH_RST;
    end else if (access && apb_req.pwrite && hit_ctrl) begin
      threshold <= apb_req.pwdata[`TOTAL_LEVEL_W-1:0];
    end
  end

  // A write of any value clears the counter, and wins over a new overflow
  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      ovf_cnt <= '0;
    end else if (access && apb_req.pwrite && hit_ovf) begin
      ovf_cnt <= '0;
    end else if (overflow && (ovf_cnt != '1)) begin
      ovf_cnt <= ovf_cnt + 1'b1;
    end
  end

  assign high = (status.level >= threshold);

  // The bus master must hold psel through the access phase
  a_penable_with_psel: assert property (
    @(posedge RD_CLK) disable iff (RESET)
    apb_req.penable |-> apb_req.psel
  ) else $error("penable without psel");

endmodule

// File: fwft_fifo.sv
// First-word-fall-through wrapper around fifo_bram
// Three valid flags and a middle register hide the RAM read latency
`include "sample_fifo_settings.svh"

module fwft_fifo
  import sample_fifo_pkg::*;
#(
  parameter type payload_t = sample_t
) (
  input  logic         RD_CLK,
  input  logic         RESET,
  input  logic         wren,
  input  payload_t     din,
  input  logic         rden,
  output payload_t     dout,
  output logic         empty,
  output logic         full,
  output logic         almost_full,
  output logic         overflow,
  output fifo_status_t status
);

  payload_t ram_dout;
  payload_t middle_dout;
  logic     ram_rden;
  logic     ram_empty;

  logic ram_valid;    // ram_dout holds a word not yet moved on
  logic middle_valid;
  logic dout_valid;
  logic will_update_middle;
  logic will_update_dout;

  logic [`TOTAL_LEVEL_W-1:0] level;
  logic                      push;
  logic                      pop;

  fifo_bram #(
    .payload_t (payload_t)
  ) i_fifo_bram (
    .RD_CLK      (RD_CLK),
    .RESET       (RESET),
    .wren        (wren),
    .din         (din),
    .ram_rden    (ram_rden),
    .ram_dout    (ram_dout),
    .ram_empty   (ram_empty),
    .full        (full),
    .almost_full (almost_full),
    .overflow    (overflow)
  );

  assign will_update_dout   = (middle_valid || ram_valid) && (rden || !dout_valid);
  // RAM word goes to middle unless it goes straight to dout this cycle
  assign will_update_middle = ram_valid && (middle_valid == will_update_dout);
  assign ram_rden           = !ram_empty && !(middle_valid && dout_valid && ram_valid);
  assign empty              = !dout_valid;

  assign push = wren && !full;
  assign pop  = rden && dout_valid;

  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      ram_valid    <= 1'b0;
      middle_valid <= 1'b0;
      dout_valid   <= 1'b0;
      dout         <= '0;
    end else begin
      if (will_update_dout) begin
        dout <= middle_valid ? middle_dout : ram_dout;
      end

      if (ram_rden) begin
        ram_valid <= 1'b1;
      end else if (will_update_middle || will_update_dout) begin
        ram_valid <= 1'b0;
      end

      if (will_update_middle) begin
        middle_valid <= 1'b1;
      end else if (will_update_dout) begin
        middle_valid <= 1'b0;
      end

      if (will_update_dout) begin
        dout_valid <= 1'b1;
      end else if (rden) begin
        dout_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (will_update_middle) begin
      middle_dout <= ram_dout;
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      level <= '0;
    end else if (push && !pop) begin
      level <= level + 1'b1;
    end else if (pop && !push) begin
      level <= level - 1'b1;
    end
  end

  assign status = '{level: level, full: full, almost_full: almost_full, empty: empty};

  a_middle_needs_dout: assert property (
    @(posedge RD_CLK) disable iff (RESET)
    middle_valid |-> dout_valid
  ) else $error("middle register valid while dout invalid");

  a_level_bound: assert property (
    @(posedge RD_CLK) disable iff (RESET)
    level <= `FIFO_DEPTH + 3
  ) else $error("level above total capacity");

endmodule

// File: fifo_bram.sv
// Synchronous FIFO on an inferred block RAM
// Read data is registered one cycle after ram_rden, flags come from the count
`include "sample_fifo_settings.svh"

module fifo_bram
  import sample_fifo_pkg::*;
#(
  parameter type payload_t = sample_t
) (
  input  logic     RD_CLK,
  input  logic     RESET,
  input  logic     wren,
  input  payload_t din,
  input  logic     ram_rden,
  output payload_t ram_dout,
  output logic     ram_empty,
  output logic     full,
  output logic     almost_full,
  output logic     overflow
);

  localparam logic [`LEVEL_W-1:0] FULL_LEVEL = `FIFO_DEPTH;
  localparam logic [`LEVEL_W-1:0] AF_LEVEL   = `FIFO_DEPTH - `ALMOST_FULL_MARGIN;

  payload_t mem [`FIFO_DEPTH];

  logic [`FIFO_AW-1:0] wr_ptr;
  logic [`FIFO_AW-1:0] rd_ptr;
  logic [`LEVEL_W-1:0] count;
  logic                wr_accept;

  assign wr_accept = wren && !full;

  // Dropped writes are flagged in the same cycle
  assign overflow = wren && full;

  assign ram_empty   = (count == '0);
  assign full        = (count == FULL_LEVEL);
  assign almost_full = (count >= AF_LEVEL);

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_accept) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (ram_rden) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      count <= '0;
    end else begin
      case ({wr_accept, ram_rden})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Simultaneous push and pop keep the count
      endcase
    end
  end

  // Storage and output register; no embedded output pipeline, the
  // prefetch stage relies on exactly one cycle of read latency
  always_ff @(posedge RD_CLK) begin
    if (wr_accept) begin
      mem[wr_ptr] <= din;
    end
    if (ram_rden) begin
      ram_dout <= mem[rd_ptr];
    end
  end

  // The prefetch stage must never pop an empty RAM
  a_no_read_when_empty: assert property (
    @(posedge RD_CLK) disable iff (RESET)
    !(ram_rden && ram_empty)
  ) else $error("fifo_bram read while empty");

endmodule

// File: sample_fifo_pkg.sv
// Sample FIFO types
// Sample payload, status word and APB request/response bundles
`include "sample_fifo_settings.svh"

package sample_fifo_pkg;

  typedef struct packed {
    logic [`CHAN_W-1:0] chan;
    logic [`DATA_W-1:0] data;
  } sample_t;

  // Level counts the RAM and all prefetch stages
  typedef struct packed {
    logic [`TOTAL_LEVEL_W-1:0] level;
    logic                      full;
    logic                      almost_full;
    logic                      empty;
  } fifo_status_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

// File: sample_fifo_settings.svh
// Sample FIFO build settings
// Depth, field widths, flag margins and APB register map
`ifndef SAMPLE_FIFO_SETTINGS_SVH
`define SAMPLE_FIFO_SETTINGS_SVH

`define FIFO_DEPTH          512 // Must be a power of two
`define FIFO_AW             9
`define LEVEL_W             10  // RAM count, covers FIFO_DEPTH
`define TOTAL_LEVEL_W       11  // RAM plus the three prefetch stages
`define ALMOST_FULL_MARGIN  4

`define CHAN_W              4
`define DATA_W              28

`define REG_CTRL            12'h000
`define REG_STATUS          12'h004
`define REG_OVF             12'h008
`define OVF_CNT_W           16

`endif
